// File: common/interconnect_pkg.sv
package interconnect_pkg;

	localparam int ADDR_BITS  = 4;
	localparam int DATA_BITS  = 16;
	localparam int FRAME_BITS = 1 + ADDR_BITS + DATA_BITS; // Flag, address, data.

	localparam int NUM_ROUTES      = 4;
	localparam int ROUTE_XBAR_DATA = 0;
	localparam int ROUTE_XBAR_CTRL = 1;
	localparam int ROUTE_LOOPBACK  = 2;
	localparam int ROUTE_MAILBOX   = 3;

	// Arbiter source indices, returned as the response address.
	localparam int NUM_ARB_INPUTS = 3;
	localparam int ARB_XBAR       = 0;
	localparam int ARB_WB         = 1;
	localparam int ARB_LOOPBACK   = 2;

	localparam logic [31:0] WB_XBAR_IN  = 32'h0;
	localparam logic [31:0] WB_XBAR_OUT = 32'h4;
	localparam logic [31:0] WB_TO_SPI   = 32'h8;
	localparam logic [31:0] WB_MAILBOX  = 32'hC;
	localparam int          WB_VALID_BIT = 31; // Set in read data when a word was popped.

	localparam int SYNC_STAGES = 2;

	typedef logic [DATA_BITS-1:0] data_t;

	typedef struct packed {
		logic [ADDR_BITS-1:0] addr;
		data_t                data;
	} addr_msg_t;

endpackage

// File: spi/spi_minion.sv
`timescale 1ns/10ps

module spi_minion import interconnect_pkg::*; (
	input  logic      clk,
	input  logic      rst_n_i,
	input  logic      cs_i,
	input  logic      sclk_i,
	input  logic      mosi_i,
	output logic      miso_o,
	output addr_msg_t send_msg_o,
	output logic      send_val_o,
	input  logic      send_rdy_i,
	input  addr_msg_t recv_msg_i,
	input  logic      recv_val_i,
	output logic      recv_rdy_o,
	output logic      parity_o,
	output logic      overrun_o
);

	logic [SYNC_STAGES-1:0] cs_sync_r;
	logic [SYNC_STAGES-1:0] sclk_sync_r;
	logic [SYNC_STAGES-1:0] mosi_sync_r;
	logic cs_prev_r;
	logic sclk_prev_r;
	logic cs_s;
	logic sclk_s;
	logic mosi_s;
	logic cs_fall;
	logic cs_rise;
	logic sclk_rise;
	logic sclk_fall;
	logic frame_done;
	logic send_busy;
	logic [FRAME_BITS-1:0] rx_r;
	logic [FRAME_BITS-1:0] tx_r;
	logic [$clog2(FRAME_BITS+1)-1:0] cnt_r;
	addr_msg_t send_msg_r;
	logic send_val_r;
	logic parity_r;
	logic overrun_r;

	assign cs_s   = cs_sync_r[SYNC_STAGES-1];
	assign sclk_s = sclk_sync_r[SYNC_STAGES-1];
	assign mosi_s = mosi_sync_r[SYNC_STAGES-1];

	assign cs_fall    = cs_prev_r && !cs_s;
	assign cs_rise    = !cs_prev_r && cs_s;
	assign sclk_rise  = !sclk_prev_r && sclk_s && !cs_s;
	assign sclk_fall  = sclk_prev_r && !sclk_s && !cs_s;
	assign frame_done = cs_rise && (cnt_r == FRAME_BITS); // Short or long frames are ignored.
	assign send_busy  = send_val_r && !send_rdy_i;

	assign recv_rdy_o = cs_fall; // Claim whatever response is pending.
	assign miso_o     = tx_r[FRAME_BITS-1];
	assign send_msg_o = send_msg_r;
	assign send_val_o = send_val_r;
	assign parity_o   = parity_r;
	assign overrun_o  = overrun_r;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cs_sync_r   <= '1;
			sclk_sync_r <= '0;
			cs_prev_r   <= 1'b1;
			sclk_prev_r <= 1'b0;
		end else begin
			cs_sync_r   <= {cs_sync_r[SYNC_STAGES-2:0], cs_i};
			sclk_sync_r <= {sclk_sync_r[SYNC_STAGES-2:0], sclk_i};
			cs_prev_r   <= cs_s;
			sclk_prev_r <= sclk_s;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			tx_r       <= '0;
			cnt_r      <= '0;
			send_val_r <= 1'b0;
			parity_r   <= 1'b0;
			overrun_r  <= 1'b0;
		end else begin
			if (send_val_r && send_rdy_i)
				send_val_r <= 1'b0;
			if (cs_fall) begin
				tx_r      <= recv_val_i ? {1'b1, recv_msg_i} : '0;
				cnt_r     <= '0;
				overrun_r <= 1'b0;
			end else if (sclk_fall) begin
				tx_r <= {tx_r[FRAME_BITS-2:0], 1'b0}; // MSB first.
			end
			if (sclk_rise && cnt_r <= FRAME_BITS)
				cnt_r <= cnt_r + 1'b1;
			if (frame_done) begin
				parity_r <= ^rx_r;
				if (rx_r[FRAME_BITS-1] && send_busy)
					overrun_r <= 1'b1; // Router still full, frame is lost.
				else if (rx_r[FRAME_BITS-1])
					send_val_r <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		mosi_sync_r <= {mosi_sync_r[SYNC_STAGES-2:0], mosi_i};
		if (sclk_rise)
			rx_r <= {rx_r[FRAME_BITS-2:0], mosi_s};
		if (frame_done && rx_r[FRAME_BITS-1] && !send_busy)
			send_msg_r <= rx_r[FRAME_BITS-2:0];
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		send_val_o && !send_rdy_i |=> send_val_o && $stable(send_msg_o))
		else $error("spi_minion: message changed or dropped before its transfer");

endmodule

// File: hw/msg_router.sv
`timescale 1ns/10ps

module msg_router import interconnect_pkg::*; #(
	parameter int NOUTPUTS = NUM_ROUTES
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  addr_msg_t           in_msg_i,
	input  logic                in_val_i,
	output logic                in_rdy_o,
	output data_t               out_msg_o [NOUTPUTS],
	output logic [NOUTPUTS-1:0] out_val_o,
	input  logic [NOUTPUTS-1:0] out_rdy_i
);

	data_t data_r;
	logic [$clog2(NOUTPUTS)-1:0] sel_r;
	logic full_r;
	logic in_xfer;

	assign in_rdy_o = !full_r || out_rdy_i[sel_r]; // Refills in the cycle it drains.
	assign in_xfer  = in_val_i && in_rdy_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			full_r <= 1'b0;
			sel_r  <= '0;
		end else begin
			if (in_xfer) begin
				full_r <= (in_msg_i.addr < NOUTPUTS); // Unmapped address is dropped here.
				sel_r  <= in_msg_i.addr[$clog2(NOUTPUTS)-1:0];
			end else if (out_rdy_i[sel_r]) begin
				full_r <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_xfer)
			data_r <= in_msg_i.data;
	end

	always_comb begin
		for (int i = 0; i < NOUTPUTS; i++) begin
			out_msg_o[i] = data_r;
			out_val_o[i] = full_r && (sel_r == i);
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(out_val_o))
		else $error("msg_router: more than one output valid");

endmodule

// File: hw/msg_arbiter.sv
`timescale 1ns/10ps

module msg_arbiter import interconnect_pkg::*; #(
	parameter int  NINPUTS = NUM_ARB_INPUTS,
	parameter type T       = data_t
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  T                   in_msg_i [NINPUTS],
	input  logic [NINPUTS-1:0] in_val_i,
	output logic [NINPUTS-1:0] in_rdy_o,
	output addr_msg_t          out_msg_o,
	output logic               out_val_o,
	input  logic               out_rdy_i
);

	typedef logic [$clog2(NINPUTS)-1:0] idx_t;

	idx_t last_r;
	idx_t gnt_r;
	idx_t pick;
	logic gnt_vld_r;
	logic found;
	logic out_free;
	logic xfer;
	logic out_val_r;
	addr_msg_t out_msg_r;

	// Search starts one past the last winner.
	always_comb begin
		int idx;
		found = 1'b0;
		pick  = '0;
		for (int k = 1; k <= NINPUTS; k++) begin
			idx = (int'(last_r) + k) % NINPUTS;
			if (!found && in_val_i[idx]) begin
				found = 1'b1;
				pick  = idx_t'(idx);
			end
		end
	end

	assign out_free = !out_val_r || out_rdy_i;
	assign xfer     = gnt_vld_r && in_val_i[gnt_r] && out_free;

	always_comb begin
		for (int i = 0; i < NINPUTS; i++)
			in_rdy_o[i] = gnt_vld_r && (gnt_r == i) && out_free;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			last_r    <= idx_t'(NINPUTS - 1); // Input 0 goes first.
			gnt_r     <= '0;
			gnt_vld_r <= 1'b0;
			out_val_r <= 1'b0;
		end else begin
			if (xfer) begin
				last_r    <= gnt_r;
				gnt_vld_r <= 1'b0;
			end else if (!gnt_vld_r && found) begin
				gnt_r     <= pick;
				gnt_vld_r <= 1'b1;
			end
			if (xfer)
				out_val_r <= 1'b1;
			else if (out_rdy_i)
				out_val_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			out_msg_r.addr <= ADDR_BITS'(gnt_r); // Tag with the source index.
			out_msg_r.data <= data_t'(in_msg_i[gnt_r]);
		end
	end

	assign out_msg_o = out_msg_r;
	assign out_val_o = out_val_r;

	assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(in_rdy_o))
		else $error("msg_arbiter: more than one input granted");

endmodule

// File: hw/blocking_xbar.sv
`timescale 1ns/10ps

module blocking_xbar import interconnect_pkg::*; #(
	parameter int  NINPUTS  = 2,
	parameter int  NOUTPUTS = 2,
	parameter type T        = data_t
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  T                    recv_msg_i [NINPUTS],
	input  logic [NINPUTS-1:0]  recv_val_i,
	output logic [NINPUTS-1:0]  recv_rdy_o,
	output T                    send_msg_o [NOUTPUTS],
	output logic [NOUTPUTS-1:0] send_val_o,
	input  logic [NOUTPUTS-1:0] send_rdy_i,
	input  data_t               ctrl_msg_i,
	input  logic                ctrl_val_i,
	output logic                ctrl_rdy_o
);

	logic [$clog2(NINPUTS)-1:0]  in_sel_r;
	logic [$clog2(NOUTPUTS)-1:0] out_sel_r;

	// A word waiting on the selected input keeps its path until it is sent.
	assign ctrl_rdy_o = !recv_val_i[in_sel_r];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			in_sel_r  <= '0;
			out_sel_r <= '0;
		end else if (ctrl_val_i && ctrl_rdy_o) begin
			in_sel_r  <= ctrl_msg_i[$clog2(NOUTPUTS) +: $clog2(NINPUTS)];
			out_sel_r <= ctrl_msg_i[$clog2(NOUTPUTS)-1:0]; // Output in the low bits.
		end
	end

	always_comb begin
		for (int i = 0; i < NINPUTS; i++)
			recv_rdy_o[i] = (in_sel_r == i) && send_rdy_i[out_sel_r];
		for (int o = 0; o < NOUTPUTS; o++) begin
			send_msg_o[o] = recv_msg_i[in_sel_r];
			send_val_o[o] = (out_sel_r == o) && recv_val_i[in_sel_r];
		end
	end

endmodule

// File: wishbone/wb_stream_adapter.sv
`timescale 1ns/10ps

module wb_stream_adapter import interconnect_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        wbs_cyc_i,
	input  logic        wbs_stb_i,
	input  logic        wbs_we_i,
	input  logic [3:0]  wbs_sel_i,
	input  logic [31:0] wbs_adr_i,
	input  logic [31:0] wbs_dat_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o,
	output data_t       xin_msg_o,
	output logic        xin_val_o,
	input  logic        xin_rdy_i,
	output data_t       spi_msg_o,
	output logic        spi_val_o,
	input  logic        spi_rdy_i,
	input  data_t       xout_msg_i,
	input  logic        xout_val_i,
	output logic        xout_rdy_o,
	input  data_t       mbox_msg_i,
	input  logic        mbox_val_i,
	output logic        mbox_rdy_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_ACK} state_e;

	state_e      state_r;
	logic [3:0]  wr_off_r;
	data_t       wr_data_r;
	logic [31:0] rd_data_r;
	logic [3:0]  off;
	logic        req;
	logic        wr_ok;
	logic        wr_done;
	logic        xout_rd;
	logic        xout_full_r;
	data_t       xout_buf_r;

	assign off   = wbs_adr_i[3:0];
	assign req   = wbs_cyc_i && wbs_stb_i && (state_r == ST_IDLE);
	assign wr_ok = (off == WB_XBAR_IN[3:0]) || (off == WB_TO_SPI[3:0]);

	// Reads pop in the request cycle, so ack follows one cycle later.
	assign xout_rd    = req && !wbs_we_i && (off == WB_XBAR_OUT[3:0]);
	assign xout_rdy_o = !xout_full_r; // One-word buffer, so a host write can loop back.
	assign mbox_rdy_o = req && !wbs_we_i && (off == WB_MAILBOX[3:0]);

	assign xin_msg_o = wr_data_r;
	assign spi_msg_o = wr_data_r;
	assign xin_val_o = (state_r == ST_WRITE) && (wr_off_r == WB_XBAR_IN[3:0]);
	assign spi_val_o = (state_r == ST_WRITE) && (wr_off_r == WB_TO_SPI[3:0]);
	assign wr_done   = (xin_val_o && xin_rdy_i) || (spi_val_o && spi_rdy_i);

	assign wbs_ack_o = (state_r == ST_ACK);
	assign wbs_dat_o = rd_data_r;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_r     <= ST_IDLE;
			wr_off_r    <= '0;
			xout_full_r <= 1'b0;
		end else begin
			case (state_r)
				ST_IDLE: begin
					if (req) begin
						state_r  <= (wbs_we_i && wr_ok) ? ST_WRITE : ST_ACK;
						wr_off_r <= off;
					end
				end
				ST_WRITE: begin
					if (wr_done)
						state_r <= ST_ACK; // Ack in the cycle after the accept.
				end
				default: state_r <= ST_IDLE;
			endcase
			if (xout_val_i && xout_rdy_o)
				xout_full_r <= 1'b1;
			else if (xout_rd)
				xout_full_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (xout_val_i && xout_rdy_o)
			xout_buf_r <= xout_msg_i;
		if (req && wbs_we_i)
			wr_data_r <= {wbs_sel_i[1] ? wbs_dat_i[15:8] : 8'h00,
				wbs_sel_i[0] ? wbs_dat_i[7:0] : 8'h00}; // Low two byte lanes.
		if (req) begin
			rd_data_r <= '0;
			if (xout_rd && xout_full_r) begin
				rd_data_r[WB_VALID_BIT]    <= 1'b1;
				rd_data_r[DATA_BITS-1:0] <= xout_buf_r;
			end
			if (mbox_rdy_o && mbox_val_i) begin
				rd_data_r[WB_VALID_BIT]    <= 1'b1;
				rd_data_r[DATA_BITS-1:0] <= mbox_msg_i;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) wbs_ack_o |=> !wbs_ack_o)
		else $error("wb_stream_adapter: ack held for two cycles");

endmodule

// File: hw/interconnect_top.sv
`timescale 1ns/10ps

module interconnect_top import interconnect_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        cs_i,
	input  logic        sclk_i,
	input  logic        mosi_i,
	output logic        miso_o,
	output logic        parity_o,
	output logic        overrun_o,
	input  logic        wbs_stb_i,
	input  logic        wbs_cyc_i,
	input  logic        wbs_we_i,
	input  logic [3:0]  wbs_sel_i,
	input  logic [31:0] wbs_dat_i,
	input  logic [31:0] wbs_adr_i,
	output logic        wbs_ack_o,
	output logic [31:0] wbs_dat_o
);

	addr_msg_t spi_send_msg;
	logic      spi_send_val;
	logic      spi_send_rdy;
	addr_msg_t arb_out_msg;
	logic      arb_out_val;
	logic      arb_out_rdy;

	data_t                    route_msg [NUM_ROUTES];
	logic [NUM_ROUTES-1:0]    route_val;
	logic [NUM_ROUTES-1:0]    route_rdy;
	data_t                    xbar_recv_msg [2];
	logic [1:0]               xbar_recv_val;
	logic [1:0]               xbar_recv_rdy;
	data_t                    xbar_send_msg [2];
	logic [1:0]               xbar_send_val;
	logic [1:0]               xbar_send_rdy;
	logic                     xbar_ctrl_rdy;
	data_t                    arb_in_msg [NUM_ARB_INPUTS];
	logic [NUM_ARB_INPUTS-1:0] arb_in_val;
	logic [NUM_ARB_INPUTS-1:0] arb_in_rdy;

	spi_minion minion (
		.clk(clk), .rst_n_i(rst_n_i),
		.cs_i(cs_i), .sclk_i(sclk_i), .mosi_i(mosi_i), .miso_o(miso_o),
		.send_msg_o(spi_send_msg), .send_val_o(spi_send_val), .send_rdy_i(spi_send_rdy),
		.recv_msg_i(arb_out_msg), .recv_val_i(arb_out_val), .recv_rdy_o(arb_out_rdy),
		.parity_o(parity_o), .overrun_o(overrun_o)
	);

	msg_router #(.NOUTPUTS(NUM_ROUTES)) router (
		.clk(clk), .rst_n_i(rst_n_i),
		.in_msg_i(spi_send_msg), .in_val_i(spi_send_val), .in_rdy_o(spi_send_rdy),
		.out_msg_o(route_msg), .out_val_o(route_val), .out_rdy_i(route_rdy)
	);

	// Route 0 and the host register share the crossbar inputs.
	assign xbar_recv_msg[0]           = route_msg[ROUTE_XBAR_DATA];
	assign xbar_recv_val[0]           = route_val[ROUTE_XBAR_DATA];
	assign route_rdy[ROUTE_XBAR_DATA] = xbar_recv_rdy[0];
	assign route_rdy[ROUTE_XBAR_CTRL] = xbar_ctrl_rdy;

	blocking_xbar #(.NINPUTS(2), .NOUTPUTS(2), .T(data_t)) xbar (
		.clk(clk), .rst_n_i(rst_n_i),
		.recv_msg_i(xbar_recv_msg), .recv_val_i(xbar_recv_val), .recv_rdy_o(xbar_recv_rdy),
		.send_msg_o(xbar_send_msg), .send_val_o(xbar_send_val), .send_rdy_i(xbar_send_rdy),
		.ctrl_msg_i(route_msg[ROUTE_XBAR_CTRL]), .ctrl_val_i(route_val[ROUTE_XBAR_CTRL]),
		.ctrl_rdy_o(xbar_ctrl_rdy)
	);

	assign arb_in_msg[ARB_XBAR]      = xbar_send_msg[0];
	assign arb_in_val[ARB_XBAR]      = xbar_send_val[0];
	assign xbar_send_rdy[0]          = arb_in_rdy[ARB_XBAR];
	assign arb_in_msg[ARB_LOOPBACK]  = route_msg[ROUTE_LOOPBACK];
	assign arb_in_val[ARB_LOOPBACK]  = route_val[ROUTE_LOOPBACK];
	assign route_rdy[ROUTE_LOOPBACK] = arb_in_rdy[ARB_LOOPBACK];

	msg_arbiter #(.NINPUTS(NUM_ARB_INPUTS), .T(data_t)) arbiter (
		.clk(clk), .rst_n_i(rst_n_i),
		.in_msg_i(arb_in_msg), .in_val_i(arb_in_val), .in_rdy_o(arb_in_rdy),
		.out_msg_o(arb_out_msg), .out_val_o(arb_out_val), .out_rdy_i(arb_out_rdy)
	);

	wb_stream_adapter wishbone (
		.clk(clk), .rst_n_i(rst_n_i),
		.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
		.wbs_sel_i(wbs_sel_i), .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
		.wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
		.xin_msg_o(xbar_recv_msg[1]), .xin_val_o(xbar_recv_val[1]),
		.xin_rdy_i(xbar_recv_rdy[1]),
		.spi_msg_o(arb_in_msg[ARB_WB]), .spi_val_o(arb_in_val[ARB_WB]),
		.spi_rdy_i(arb_in_rdy[ARB_WB]),
		.xout_msg_i(xbar_send_msg[1]), .xout_val_i(xbar_send_val[1]),
		.xout_rdy_o(xbar_send_rdy[1]),
		.mbox_msg_i(route_msg[ROUTE_MAILBOX]), .mbox_val_i(route_val[ROUTE_MAILBOX]),
		.mbox_rdy_o(route_rdy[ROUTE_MAILBOX])
	);

endmodule

// File: bench/interconnect_checker.sv
`timescale 1ns/10ps

module interconnect_checker import interconnect_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  cs_i,
	input  logic                  sclk_i,
	input  logic                  miso_i,
	input  logic                  parity_i,
	input  logic                  overrun_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic                  wb_ack_i,
	input  logic [31:0]           wb_dat_i,
	input  logic [FRAME_BITS-1:0] exp_frame_i,
	input  logic                  exp_parity_i,
	input  logic [31:0]           exp_rdata_i,
	input  int                    timeouts_i,
	input  logic                  done_i,
	output int                    err_count_o
);

	logic [FRAME_BITS-1:0] rx_r;
	int spi_errs = 0;
	int par_errs = 0;
	int wb_errs  = 0;

	// Host side samples miso on the rising sclk edge.
	always @(posedge sclk_i) begin
		if (!cs_i)
			rx_r <= {rx_r[FRAME_BITS-2:0], miso_i};
	end

	always @(posedge cs_i) begin
		if (rst_n_i === 1'b1) begin
			if (rx_r !== exp_frame_i) begin
				spi_errs++;
				$display("Mismatch at %0t: miso_o frame is %h, expected %h",
					$time, rx_r, exp_frame_i);
			end
			repeat (6) @(posedge clk); // Parity settles after the synchronizers.
			if (parity_i !== exp_parity_i) begin
				par_errs++;
				$display("Mismatch at %0t: parity_o is %b, expected %b",
					$time, parity_i, exp_parity_i);
			end
			if (overrun_i !== 1'b0) begin
				spi_errs++;
				$display("Mismatch at %0t: overrun_o is %b, expected 0", $time, overrun_i);
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n_i && wb_ack_i && wb_cyc_i && wb_stb_i && !wb_we_i &&
				wb_dat_i !== exp_rdata_i) begin
			wb_errs++;
			$display("Mismatch at %0t: wbs_dat_o is %h, expected %h",
				$time, wb_dat_i, exp_rdata_i);
		end
	end

	assign err_count_o = spi_errs + par_errs + wb_errs + timeouts_i;

	always @(posedge done_i)
		$display("Errors: %0d SPI frame, %0d parity, %0d Wishbone read, %0d timeout",
			spi_errs, par_errs, wb_errs, timeouts_i);

endmodule

// File: bench/tb_interconnect.sv
`timescale 1ns/10ps

module tb_interconnect import interconnect_pkg::*; ();

	localparam int HALF        = 6; // sclk half period in clk cycles.
	localparam int WB_TIMEOUT  = 200;
	localparam int PORT_SPI    = 0;
	localparam int PORT_WB_XIN = 1;
	localparam int PORT_WB_SPI = 2;

	logic clk, rst_n, cs, sclk, mosi;
	logic miso, parity, overrun;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [3:0] wb_sel;
	logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
	logic [FRAME_BITS-1:0] exp_frame;
	logic exp_parity;
	logic [31:0] exp_rdata;
	logic [31:0] pending_word;
	logic done;
	int timeouts;
	int err_count;

	// Reference model state: crossbar selection and arbiter contents.
	int xb_in, xb_out, last_src;
	logic out_v;
	logic [FRAME_BITS-1:0] out_frame;
	logic [FRAME_BITS-1:0] held [NUM_ARB_INPUTS];
	logic [NUM_ARB_INPUTS-1:0] held_v;

	interconnect_top dut0 (
		.clk(clk), .rst_n_i(rst_n), .cs_i(cs), .sclk_i(sclk), .mosi_i(mosi),
		.miso_o(miso), .parity_o(parity), .overrun_o(overrun),
		.wbs_stb_i(wb_stb), .wbs_cyc_i(wb_cyc), .wbs_we_i(wb_we), .wbs_sel_i(wb_sel),
		.wbs_dat_i(wb_dat_w), .wbs_adr_i(wb_adr), .wbs_ack_o(wb_ack), .wbs_dat_o(wb_dat_r)
	);

	interconnect_checker check0 (
		.clk(clk), .rst_n_i(rst_n), .cs_i(cs), .sclk_i(sclk), .miso_i(miso),
		.parity_i(parity), .overrun_i(overrun), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
		.wb_we_i(wb_we), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r), .exp_frame_i(exp_frame),
		.exp_parity_i(exp_parity), .exp_rdata_i(exp_rdata), .timeouts_i(timeouts),
		.done_i(done), .err_count_o(err_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Where a message ends up: arbiter source index, or -1 with a host word.
	function automatic int predict(input int port, input logic [ADDR_BITS-1:0] addr,
			input data_t data, output logic [31:0] word);
		word = '0;
		if (port == PORT_WB_SPI)
			return ARB_WB;
		if (port == PORT_SPI && addr == ROUTE_LOOPBACK)
			return ARB_LOOPBACK;
		if (port == PORT_SPI && addr == ROUTE_MAILBOX) begin
			word = (32'd1 << WB_VALID_BIT) | 32'(data);
			return -1;
		end
		if ((port == PORT_SPI && addr == ROUTE_XBAR_DATA && xb_in == 0) ||
				(port == PORT_WB_XIN && xb_in == 1)) begin
			if (xb_out == 0)
				return ARB_XBAR;
			word = (32'd1 << WB_VALID_BIT) | 32'(data);
		end
		return -1;
	endfunction

	task automatic offer(input int src, input data_t data);
		logic [FRAME_BITS-1:0] frame;
		frame = {1'b1, ADDR_BITS'(src), data};
		if (!out_v) begin
			out_frame = frame;
			out_v     = 1'b1;
			last_src  = src;
		end else begin
			held[src]   = frame;
			held_v[src] = 1'b1;
		end
	endtask

	// A frame start takes the registered response, then round robin refills it.
	task automatic claim_response(output logic [FRAME_BITS-1:0] frame);
		int idx;
		frame = out_v ? out_frame : '0;
		out_v = 1'b0;
		for (int k = 1; k <= NUM_ARB_INPUTS; k++) begin
			idx = (last_src + k) % NUM_ARB_INPUTS;
			if (!out_v && held_v[idx]) begin
				out_frame   = held[idx];
				out_v       = 1'b1;
				held_v[idx] = 1'b0;
				last_src    = idx;
			end
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic spi_frame(input logic [FRAME_BITS-1:0] tx);
		claim_response(exp_frame);
		exp_parity = ^tx;
		wait_cycles(1);
		cs = 1'b0;
		wait_cycles(HALF);
		for (int i = FRAME_BITS - 1; i >= 0; i--) begin
			mosi = tx[i]; // MSB first.
			wait_cycles(HALF);
			sclk = 1'b1;
			wait_cycles(HALF);
			sclk = 1'b0;
		end
		mosi = 1'b0;
		wait_cycles(HALF);
		cs = 1'b1;
		wait_cycles(12); // Response is ready within 10 cycles.
	endtask

	task automatic wait_ack(input string what);
		int n;
		n = 0;
		wait_cycles(1);
		while (!wb_ack && n < WB_TIMEOUT) begin
			wait_cycles(1);
			n++;
		end
		if (!wb_ack) begin
			$display("Timeout: Wishbone %s at offset %h was never acknowledged", what, wb_adr);
			timeouts++;
		end
		wait_cycles(1);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [31:0] off, input logic [31:0] expect_word);
		wait_cycles(1);
		exp_rdata = expect_word;
		wb_adr    = off;
		wb_we     = 1'b0;
		wb_cyc    = 1'b1;
		wb_stb    = 1'b1;
		wait_ack("read");
	endtask

	task automatic wb_write(input logic [31:0] off, input data_t data);
		wait_cycles(1);
		wb_adr   = off;
		wb_dat_w = {16'h0, data};
		wb_we    = 1'b1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wait_ack("write");
	endtask

	task automatic send(input int port, input logic [ADDR_BITS-1:0] addr, input data_t data);
		int src;
		logic [31:0] word;
		src = predict(port, addr, data, word);
		if (port == PORT_SPI)
			spi_frame({1'b1, addr, data});
		else
			wb_write(port == PORT_WB_XIN ? WB_XBAR_IN : WB_TO_SPI, data);
		if (port == PORT_SPI && addr == ROUTE_XBAR_CTRL) begin
			xb_in  = int'(data[1]);
			xb_out = int'(data[0]);
		end
		if (src >= 0)
			offer(src, data);
		pending_word = word;
	endtask

	initial begin
		cs = 1'b1;
		sclk = 1'b0;
		mosi = 1'b0;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_sel = 4'hF;
		wb_adr = '0;
		wb_dat_w = '0;
		exp_frame = '0;
		exp_parity = 1'b0;
		exp_rdata = '0;
		pending_word = '0;
		done = 1'b0;
		timeouts = 0;
		xb_in = 0;
		xb_out = 0;
		last_src = NUM_ARB_INPUTS - 1;
		out_v = 1'b0;
		held_v = '0;
		void'($urandom(63));
		wait_cycles(10);
		rst_n = 1'b1;
		wait_cycles(2);

		wb_read(WB_XBAR_OUT, '0);
		spi_frame('0);

		send(PORT_SPI, ROUTE_LOOPBACK, data_t'($urandom));
		spi_frame('0);

		send(PORT_SPI, ROUTE_XBAR_DATA, data_t'($urandom));
		spi_frame('0);
		send(PORT_SPI, ROUTE_XBAR_CTRL, 16'h1); // Input 0 to output 1.
		send(PORT_SPI, ROUTE_XBAR_DATA, data_t'($urandom));
		wb_read(WB_XBAR_OUT, pending_word);
		send(PORT_SPI, ROUTE_XBAR_CTRL, 16'h2); // Input 1 to output 0.
		send(PORT_WB_XIN, '0, data_t'($urandom));
		spi_frame('0);
		send(PORT_SPI, ROUTE_XBAR_CTRL, 16'h3); // Input 1 to output 1.
		send(PORT_WB_XIN, '0, data_t'($urandom));
		wb_read(WB_XBAR_OUT, pending_word);
		send(PORT_SPI, ROUTE_XBAR_CTRL, 16'h0);

		send(PORT_SPI, ROUTE_MAILBOX, data_t'($urandom));
		wb_read(WB_MAILBOX, pending_word);
		send(PORT_WB_SPI, '0, data_t'($urandom));
		spi_frame('0);

		send(PORT_SPI, 4'd7, data_t'($urandom));
		spi_frame('0);
		wb_read(WB_XBAR_OUT, '0);
		wb_read(WB_MAILBOX, '0);

		// Host message first, it fills the arbiter output right away.
		send(PORT_WB_SPI, '0, data_t'($urandom));
		send(PORT_SPI, ROUTE_LOOPBACK, data_t'($urandom));
		send(PORT_SPI, ROUTE_XBAR_DATA, data_t'($urandom));
		repeat (4) spi_frame('0);

		done = 1'b1;
		wait_cycles(1);
		if (err_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: filelist.f
common/interconnect_pkg.sv
spi/spi_minion.sv
hw/msg_router.sv
hw/msg_arbiter.sv
hw/blocking_xbar.sv
wishbone/wb_stream_adapter.sv
hw/interconnect_top.sv
bench/interconnect_checker.sv
bench/tb_interconnect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the interconnect testbench with Verilator, runs it and scans the log.
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_interconnect -f filelist.f -o tb_interconnect
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_interconnect > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation passed"
exit 0
